// File: verilog.f
+incdir+verilog
verilog/ffe_pkg.sv
verilog/axil_pkg.sv
verilog/ffe_weight_regs.sv
verilog/ffe_datapath.sv
verilog/ffe_result_sat.sv
verilog/ffe_top.sv
tb/tb_clk_gen.sv
tb/ffe_tb.sv

// File: Bender.yml
package:
  name: ffe

export_include_dirs:
  - verilog

sources:
  - verilog/ffe_pkg.sv
  - verilog/axil_pkg.sv
  - verilog/ffe_weight_regs.sv
  - verilog/ffe_datapath.sv
  - verilog/ffe_result_sat.sv
  - verilog/ffe_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/ffe_tb.sv

// File: tb/ffe_tb.sv
`timescale 1ns/1ps
`include "ffe_cfg.svh"

module ffe_tb;
   import ffe_pkg::*;
   import axil_pkg::*;

   localparam int NUM_TESTS = 6;
   localparam int CLK_PERIOD_NS = 4;
   localparam int AXI_WAIT_LIMIT = 50;
   localparam int RES_MAX = (1 << (`FFE_RESULT_BITS - 1)) - 1;
   localparam int RES_MIN = -RES_MAX - 1;
   localparam axil_addr_t COMMIT_ADDR = 8'h20;

   logic clk;
   logic rst;
   logic codes_valid;
   logic results_valid;
   code_t codes [`FFE_WIDTH-1:0];
   result_t results [`FFE_WIDTH-1:0];
   logic awvalid, wvalid, bready, arvalid, rready;
   logic awready, wready, bvalid, arready, rvalid;
   axil_addr_t awaddr, araddr;
   axil_data_t wdata, rdata;
   axil_resp_t bresp, rresp;

   // Reference model state.
   code_t stim [`FFE_WIDTH-1:0];
   int prev_word [`FFE_WIDTH];
   int shadow_w [`FFE_LENGTH];
   int active_w [`FFE_LENGTH];
   result_t exp_q [$];
   logic [2:0] valid_pipe = '0;
   int aw_pulses = 0;
   int ar_pulses = 0;

   tb_clk_gen clk_gen (.clk, .rst);

   ffe_top dut0 (
      .clk, .rst, .codes_valid, .codes, .results_valid, .results,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp
   );

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_result(input result_t got, input result_t expected, input int lane);
      if (got !== expected)
         report_error($sformatf("lane %0d result %0d, expected %0d", lane, got, expected));
   endtask

   task automatic check_resp(input axil_resp_t got, input axil_resp_t expected, input string what);
      if (got !== expected)
         report_error($sformatf("%s is %0d, expected %0d", what, got, expected));
   endtask

   task automatic check_data(input axil_data_t got, input axil_data_t expected);
      if (got !== expected)
         report_error($sformatf("read data 0x%08h, expected 0x%08h", got, expected));
   endtask

   // Cycle alignment of valid, then values in stream order.
   always @(posedge clk) begin
      if (rst)
         valid_pipe <= '0;
      else
         valid_pipe <= {valid_pipe[1:0], codes_valid};
   end

   always @(negedge clk) begin
      if (rst === 1'b0) begin
         if (results_valid !== valid_pipe[2])
            report_error("results_valid does not follow codes_valid by 3 cycles");
         if (results_valid === 1'b1) begin
            if (exp_q.size() < `FFE_WIDTH)
               abort_run("A result word appeared with no matching input word.");
            for (int j = 0; j < `FFE_WIDTH; j++)
               check_result(results[j], exp_q.pop_front(), j);
         end
      end
   end

   // Ready pulses counted on the edge that accepts the request.
   always @(posedge clk) begin
      if (rst === 1'b0) begin
         if (awready !== wready)
            report_error("awready and wready are not raised together");
         if (awready === 1'b1)
            aw_pulses++;
         if (arready === 1'b1)
            ar_pulses++;
      end
   end

   function automatic int weight_of(input axil_data_t d);
      int v;
      v = int'(d[`FFE_WEIGHT_BITS-1:0]);
      if (v >= (1 << (`FFE_WEIGHT_BITS - 1)))
         v = v - (1 << `FFE_WEIGHT_BITS);
      return v;
   endfunction

   // Lane j, tap i sees the sample i positions earlier in the serial stream.
   task automatic push_expected();
      int window [2*`FFE_WIDTH];
      int acc;
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         window[j] = prev_word[j];
         window[`FFE_WIDTH + j] = int'(stim[j]);
      end
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         acc = 0;
         for (int i = 0; i < `FFE_LENGTH; i++)
            acc += active_w[i] * window[`FFE_WIDTH + j - i];
         acc = (acc + (1 << (`FFE_SHIFT - 1))) >>> `FFE_SHIFT;
         acc = (acc > RES_MAX) ? RES_MAX : ((acc < RES_MIN) ? RES_MIN : acc);
         exp_q.push_back(result_t'(acc));
         prev_word[j] = int'(stim[j]);
      end
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
      axil_resp_t exp_resp;
      int waited;
      int aw_start;
      exp_resp = RESP_SLVERR;
      @(negedge clk);
      aw_start = aw_pulses;
      awaddr = addr;
      wdata = data;
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > AXI_WAIT_LIMIT)
            abort_run("An AXI write got no response.");
      end while (bvalid !== 1'b1);
      awvalid = 1'b0;
      wvalid = 1'b0;
      if (aw_pulses - aw_start != 1)
         report_error($sformatf("awready pulsed %0d times for one write, expected 1",
                                aw_pulses - aw_start));
      if (addr[1:0] == 2'b00 && addr / 4 < `FFE_LENGTH) begin
         shadow_w[addr / 4] = weight_of(data);
         exp_resp = RESP_OKAY;
      end else if (addr == COMMIT_ADDR) begin
         active_w = shadow_w;
         exp_resp = RESP_OKAY;
      end
      check_resp(bresp, exp_resp, "write response");
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axil_read(input axil_addr_t addr);
      axil_resp_t exp_resp;
      axil_data_t exp_data;
      int waited;
      int ar_start;
      exp_resp = RESP_OKAY;
      exp_data = '0;
      if (addr[1:0] == 2'b00 && addr / 4 < `FFE_LENGTH)
         exp_data = axil_data_t'(shadow_w[addr / 4]);
      else if (addr != COMMIT_ADDR)
         exp_resp = RESP_SLVERR;
      @(negedge clk);
      ar_start = ar_pulses;
      araddr = addr;
      arvalid = 1'b1;
      rready = 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > AXI_WAIT_LIMIT)
            abort_run("An AXI read got no response.");
      end while (rvalid !== 1'b1);
      arvalid = 1'b0;
      if (ar_pulses - ar_start != 1)
         report_error($sformatf("arready pulsed %0d times for one read, expected 1",
                                ar_pulses - ar_start));
      check_resp(rresp, exp_resp, "read response");
      if (exp_resp == RESP_OKAY)
         check_data(rdata, exp_data);
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic send_codes();
      @(negedge clk);
      codes = stim;
      codes_valid = 1'b1;
      push_expected();
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         codes_valid = 1'b0;
      end
   endtask

   task automatic drain_results();
      idle_cycles(5);
      if (exp_q.size() != 0)
         abort_run($sformatf("%0d expected results never appeared.", exp_q.size()));
   endtask

   task automatic stream_random(input int words, input bit gaps);
      for (int n = 0; n < words; n++) begin
         for (int j = 0; j < `FFE_WIDTH; j++)
            stim[j] = code_t'($urandom_range(0, 255));
         send_codes();
         if (gaps && $urandom_range(0, 3) == 0)
            idle_cycles(1);
      end
      drain_results();
   endtask

   task automatic load_weights(input int w0, input int w1, input int w2, input int w3);
      axil_write(8'h00, axil_data_t'(w0));
      axil_write(8'h04, axil_data_t'(w1));
      axil_write(8'h08, axil_data_t'(w2));
      axil_write(8'h0C, axil_data_t'(w3));
      axil_write(COMMIT_ADDR, 32'd1);
   endtask

   task automatic reset_and_readback();
      @(negedge clk);
      if (results_valid !== 1'b0)
         abort_run("results_valid is not low after reset.");
      if ({bvalid, rvalid, awready, wready, arready} !== 5'b0)
         abort_run("An AXI valid or ready output is not low after reset.");
      axil_write(8'h00, 32'h0000_0010);
      axil_write(8'h04, 32'hABCD_E3F5);
      axil_write(8'h08, 32'h0000_0200);
      axil_write(8'h0C, 32'h1234_51FF);
      for (int i = 0; i < `FFE_LENGTH; i++)
         axil_read(axil_addr_t'(4 * i));
      axil_read(COMMIT_ADDR);
   endtask

   task automatic unmapped_access();
      axil_write(8'h10, 32'h0000_0155);
      axil_write(8'h24, 32'h0000_0001);
      axil_write(8'h11, 32'h0000_0001);
      axil_read(8'h30);
      axil_read(8'h06);
      for (int i = 0; i < `FFE_LENGTH; i++)
         axil_read(axil_addr_t'(4 * i));
      // Active bank was never committed, so results stay zero.
      stream_random(3, 1'b0);
   endtask

   task automatic unity_passthrough();
      load_weights(16, 0, 0, 0);
      for (int n = 0; n < 8; n++) begin
         for (int j = 0; j < `FFE_WIDTH; j++)
            stim[j] = code_t'(n * 29 + j * 7 - 100);
         send_codes();
      end
      drain_results();
   endtask

   task automatic saturation_limits();
      load_weights(511, 511, 511, 511);
      for (int n = 0; n < 6; n++) begin
         for (int j = 0; j < `FFE_WIDTH; j++)
            stim[j] = (n < 3) ? code_t'(127) : code_t'(-128);
         send_codes();
      end
      drain_results();
   endtask

   task automatic shadow_isolation();
      load_weights(16, 0, 0, 0);
      axil_write(8'h00, 32'd0);
      axil_write(8'h04, axil_data_t'(-16));
      stream_random(6, 1'b1);
      axil_write(COMMIT_ADDR, 32'd1);
      stream_random(6, 1'b1);
   endtask

   initial begin
      void'($urandom(37690));
      codes_valid = 1'b0;
      codes = '{default: '0};
      stim = '{default: '0};
      {awvalid, wvalid, bready, arvalid, rready} = '0;
      awaddr = '0;
      araddr = '0;
      wdata = '0;
      do @(posedge clk); while (rst !== 1'b0);
      reset_and_readback();
      unmapped_access();
      unity_passthrough();
      load_weights(int'($urandom_range(0, 80)) - 40, int'($urandom_range(0, 80)) - 40,
                   int'($urandom_range(0, 80)) - 40, int'($urandom_range(0, 80)) - 40);
      stream_random(40, 1'b1);
      saturation_limits();
      shadow_isolation();
      $display("TEST PASS");
      $finish;
   end

   initial begin
      #(NUM_TESTS * 2000 * CLK_PERIOD_NS);
      $display("The run timed out before all tests finished.");
      $display("TEST FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 2,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // Released on a falling edge.
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// File: verilog/ffe_top.sv
`timescale 1ns/1ps
`include "ffe_cfg.svh"

module ffe_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 codes_valid,
   input  ffe_pkg::code_t       codes [`FFE_WIDTH-1:0],
   output logic                 results_valid,
   output ffe_pkg::result_t     results [`FFE_WIDTH-1:0],
   input  logic                 awvalid,
   output logic                 awready,
   input  axil_pkg::axil_addr_t awaddr,
   input  logic                 wvalid,
   output logic                 wready,
   input  axil_pkg::axil_data_t wdata,
   output logic                 bvalid,
   input  logic                 bready,
   output axil_pkg::axil_resp_t bresp,
   input  logic                 arvalid,
   output logic                 arready,
   input  axil_pkg::axil_addr_t araddr,
   output logic                 rvalid,
   input  logic                 rready,
   output axil_pkg::axil_data_t rdata,
   output axil_pkg::axil_resp_t rresp
);
   import ffe_pkg::*;

   weight_t weights [`FFE_LENGTH-1:0];
   logic acc_valid;
   acc_t accs [`FFE_WIDTH-1:0];

   ffe_weight_regs u_regs (
      .clk, .rst,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
      .bvalid, .bready, .bresp,
      .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
      .weights
   );

   ffe_datapath u_datapath (
      .clk, .rst, .codes_valid, .codes, .weights, .acc_valid, .accs
   );

   ffe_result_sat u_result (
      .clk, .rst, .acc_valid, .accs, .results_valid, .results
   );

endmodule

// File: verilog/ffe_result_sat.sv
`timescale 1ns/1ps
`include "ffe_cfg.svh"

module ffe_result_sat (
   input  logic             clk,
   input  logic             rst,
   input  logic             acc_valid,
   input  ffe_pkg::acc_t    accs [`FFE_WIDTH-1:0],
   output logic             results_valid,
   output ffe_pkg::result_t results [`FFE_WIDTH-1:0]
);
   import ffe_pkg::*;

   localparam acc_t HALF_LSB = acc_t'(1) <<< (`FFE_SHIFT - 1);
   localparam acc_t RES_MAX = (acc_t'(1) <<< (`FFE_RESULT_BITS - 1)) - acc_t'(1);
   localparam acc_t RES_MIN = -RES_MAX - acc_t'(1);

   acc_t sat [`FFE_WIDTH-1:0];

   // Round half up, drop fraction bits, clamp.
   always_comb begin
      acc_t shifted;
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         shifted = (accs[j] + HALF_LSB) >>> `FFE_SHIFT;
         if (shifted > RES_MAX) begin
            sat[j] = RES_MAX;
         end else if (shifted < RES_MIN) begin
            sat[j] = RES_MIN;
         end else begin
            sat[j] = shifted;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         results[j] <= result_t'(sat[j]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         results_valid <= 1'b0;
      end else begin
         results_valid <= acc_valid;
      end
   end

endmodule

// File: verilog/ffe_datapath.sv
`timescale 1ns/1ps
`include "ffe_cfg.svh"

module ffe_datapath (
   input  logic             clk,
   input  logic             rst,
   input  logic             codes_valid,
   input  ffe_pkg::code_t   codes [`FFE_WIDTH-1:0],
   input  ffe_pkg::weight_t weights [`FFE_LENGTH-1:0],
   output logic             acc_valid,
   output ffe_pkg::acc_t    accs [`FFE_WIDTH-1:0]
);
   import ffe_pkg::*;

   code_t history [`FFE_WIDTH-1:0];
   code_t window [`FFE_WIDTH-1:0][`FFE_LENGTH-1:0];
   acc_t prods [`FFE_WIDTH-1:0][`FFE_LENGTH-1:0];
   acc_t sums [`FFE_WIDTH-1:0];
   logic prod_valid;

   // Previous accepted word, for taps reaching back across the boundary.
   always_ff @(posedge clk) begin
      if (rst) begin
         history <= '{default: '0};
      end else if (codes_valid) begin
         history <= codes;
      end
   end

   // Lane j, tap i sees the sample i positions earlier in the stream.
   for (genvar j = 0; j < `FFE_WIDTH; j++) begin : g_lane
      for (genvar i = 0; i < `FFE_LENGTH; i++) begin : g_tap
         if (j >= i) begin : g_cur
            assign window[j][i] = codes[j - i];
         end else begin : g_prev
            assign window[j][i] = history[`FFE_WIDTH + j - i];
         end
      end
   end

   // Stage 1.
   always_ff @(posedge clk) begin
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         for (int i = 0; i < `FFE_LENGTH; i++) begin
            prods[j][i] <= window[j][i] * weights[i];
         end
      end
   end

   always_comb begin
      for (int j = 0; j < `FFE_WIDTH; j++) begin
         sums[j] = '0;
         for (int i = 0; i < `FFE_LENGTH; i++) begin
            sums[j] = sums[j] + prods[j][i];
         end
      end
   end

   // Stage 2.
   always_ff @(posedge clk) begin
      accs <= sums;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         prod_valid <= 1'b0;
         acc_valid <= 1'b0;
      end else begin
         prod_valid <= codes_valid;
         acc_valid <= prod_valid;
      end
   end

endmodule

// File: verilog/ffe_weight_regs.sv
`timescale 1ns/1ps
`include "ffe_cfg.svh"

module ffe_weight_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 awvalid,
   output logic                 awready,
   input  axil_pkg::axil_addr_t awaddr,
   input  logic                 wvalid,
   output logic                 wready,
   input  axil_pkg::axil_data_t wdata,
   output logic                 bvalid,
   input  logic                 bready,
   output axil_pkg::axil_resp_t bresp,
   input  logic                 arvalid,
   output logic                 arready,
   input  axil_pkg::axil_addr_t araddr,
   output logic                 rvalid,
   input  logic                 rready,
   output axil_pkg::axil_data_t rdata,
   output axil_pkg::axil_resp_t rresp,
   output ffe_pkg::weight_t     weights [`FFE_LENGTH-1:0]
);
   import axil_pkg::*;
   import ffe_pkg::*;

   localparam axil_addr_t COMMIT_ADDR = axil_addr_t'('h20);
   localparam int IDX_BITS = `AXIL_ADDR_BITS - 2;
   localparam int DATA_BITS = $bits(axil_data_t);

   wr_state_t wr_state;
   rd_state_t rd_state;
   weight_t shadow [`FFE_LENGTH-1:0];
   logic wr_take;
   logic rd_take;
   logic [IDX_BITS-1:0] wr_idx;
   logic [IDX_BITS-1:0] rd_idx;
   logic wr_is_tap;
   logic wr_is_commit;
   logic rd_is_tap;
   logic rd_is_commit;
   axil_data_t rd_word;

   // Tap i lives at 4*i.
   assign wr_idx = awaddr[`AXIL_ADDR_BITS-1:2];
   assign rd_idx = araddr[`AXIL_ADDR_BITS-1:2];
   assign wr_is_tap = (awaddr[1:0] == 2'b00) && (wr_idx < `FFE_LENGTH);
   assign rd_is_tap = (araddr[1:0] == 2'b00) && (rd_idx < `FFE_LENGTH);
   assign wr_is_commit = (awaddr == COMMIT_ADDR);
   assign rd_is_commit = (araddr == COMMIT_ADDR);

   assign wr_take = (wr_state == WR_IDLE) && awvalid && wvalid;
   assign awready = wr_take;
   assign wready = wr_take;
   assign bvalid = (wr_state == WR_RESP);

   assign rd_take = (rd_state == RD_IDLE) && arvalid;
   assign arready = rd_take;
   assign rvalid = (rd_state == RD_DATA);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_state <= WR_IDLE;
         bresp <= RESP_OKAY;
         shadow <= '{default: '0};
         weights <= '{default: '0};
      end else begin
         case (wr_state)
            WR_IDLE: begin
               if (wr_take) begin
                  wr_state <= WR_RESP;
                  bresp <= (wr_is_tap || wr_is_commit) ? RESP_OKAY : RESP_SLVERR;
                  for (int i = 0; i < `FFE_LENGTH; i++) begin
                     if (wr_is_tap && wr_idx == i) begin
                        shadow[i] <= weight_t'(wdata[`FFE_WEIGHT_BITS-1:0]);
                     end
                  end
                  // Whole set moves at once.
                  if (wr_is_commit) begin
                     weights <= shadow;
                  end
               end
            end
            WR_RESP: begin
               if (bready) begin
                  wr_state <= WR_IDLE;
               end
            end
            default: wr_state <= WR_IDLE;
         endcase
      end
   end

   // Sign-extended shadow tap, zero elsewhere.
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < `FFE_LENGTH; i++) begin
         if (rd_is_tap && rd_idx == i) begin
            rd_word = {{(DATA_BITS - `FFE_WEIGHT_BITS){shadow[i][`FFE_WEIGHT_BITS-1]}}, shadow[i]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_state <= RD_IDLE;
         rresp <= RESP_OKAY;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (rd_take) begin
                  rd_state <= RD_DATA;
                  rresp <= (rd_is_tap || rd_is_commit) ? RESP_OKAY : RESP_SLVERR;
               end
            end
            RD_DATA: begin
               if (rready) begin
                  rd_state <= RD_IDLE;
               end
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_take) begin
         rdata <= rd_word;
      end
   end

endmodule

// File: verilog/axil_pkg.sv
`include "ffe_cfg.svh"

package axil_pkg;

   typedef logic [`AXIL_ADDR_BITS-1:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0] axil_resp_t;

   localparam axil_resp_t RESP_OKAY = 2'd0;
   localparam axil_resp_t RESP_SLVERR = 2'd2;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
   typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

// File: verilog/ffe_pkg.sv
`include "ffe_cfg.svh"

package ffe_pkg;

   // One ADC code.
   typedef logic signed [`FFE_CODE_BITS-1:0] code_t;

   // One tap weight, FFE_SHIFT fraction bits.
   typedef logic signed [`FFE_WEIGHT_BITS-1:0] weight_t;

   // Full precision lane sum.
   typedef logic signed [`FFE_ACC_BITS-1:0] acc_t;

   // Equalized output.
   typedef logic signed [`FFE_RESULT_BITS-1:0] result_t;

endpackage

// File: verilog/ffe_cfg.svh
`ifndef FFE_CFG_SVH
`define FFE_CFG_SVH

// Parallel lanes per clock.
`define FFE_WIDTH 4
// Tap count, at most FFE_WIDTH + 1 with one word of history.
`define FFE_LENGTH 4

`define FFE_CODE_BITS 8
`define FFE_WEIGHT_BITS 10
// Code + weight + log2(taps) + one margin bit.
`define FFE_ACC_BITS 21
`define FFE_RESULT_BITS 10
// Fraction bits in a weight.
`define FFE_SHIFT 4

`define AXIL_ADDR_BITS 8

`endif
